// ==== include/ddr_mux_defs.svh ====
// widths, queue depths and port count of the DDR access multiplexer
`ifndef DDR_MUX_DEFS_SVH
`define DDR_MUX_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// local bus
//////////////////////////////////////////////////////////////////////

// address of one full-width word
`define DDR_MUX_ADDR_W 32

// data word, every access is a single beat
`define DDR_MUX_DATA_W 32

//////////////////////////////////////////////////////////////////////
// queues
//////////////////////////////////////////////////////////////////////

// entries per host port request FIFO, power of two
`define DDR_MUX_REQ_DEPTH 4

// outstanding reads tracked by the tag FIFO, power of two
`define DDR_MUX_TAG_DEPTH 8

// host ports, even index writes, odd index reads
`define DDR_MUX_PORTS 4

`endif

// ==== src/ddr_mux_pkg.sv ====
// package with address, data, write request, port tag and local command types
`include "ddr_mux_defs.svh"

package ddr_mux_pkg;

	//////////////////////////////////////////////////////////////////////
	// basic words
	//////////////////////////////////////////////////////////////////////

	typedef logic [`DDR_MUX_ADDR_W-1:0] addr_t;
	typedef logic [`DDR_MUX_DATA_W-1:0] data_t;

	// host port index, also carried as the read tag
	typedef logic [$clog2(`DDR_MUX_PORTS)-1:0] port_tag_t;

	//////////////////////////////////////////////////////////////////////
	// request and command
	//////////////////////////////////////////////////////////////////////

	// queued by a write port
	typedef struct packed {
		addr_t addr;
		data_t data;
	} wr_req_t;

	// held on the local bus until local_ready
	typedef struct packed {
		addr_t address;
		data_t wdata;
		logic  write_req;
		logic  read_req;
	} local_cmd_t;

endpackage

// ==== src/port_req_fifo.sv ====
// port_req_fifo: per-port request queue with a type-parameter payload
`timescale 1ns/10ps
`include "ddr_mux_defs.svh"

module port_req_fifo #(
	parameter type payload_t = ddr_mux_pkg::addr_t
) (
	input  logic     afi_phy_clk,
	input  logic     arst_n,
	// host side
	input  logic     req,
	input  payload_t req_payload,
	output logic     ready,
	// arbiter side
	input  logic     pop,
	output payload_t head,
	output logic     not_empty
);

	localparam int DEPTH = `DDR_MUX_REQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               push;

	// host may push only while there is room
	assign ready     = (count != CNT_W'(DEPTH));
	assign not_empty = (count != '0);
	assign push      = req & ready;

	// show-ahead head for the arbiter
	assign head = mem[rd_ptr];

	always_ff @(posedge afi_phy_clk)
	begin
		if (push)
		begin
			mem[wr_ptr] <= req_payload;
		end
	end

	// pointers wrap by themselves, depth is a power of two
	always_ff @(posedge afi_phy_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + PTR_W'(1);
			if (pop)
				rd_ptr <= rd_ptr + PTR_W'(1);
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

endmodule

// ==== src/ddr_cmd_arbiter.sv ====
// ddr_cmd_arbiter: port selection, local command register and stall handling
`timescale 1ns/10ps
`include "ddr_mux_defs.svh"

module ddr_cmd_arbiter (
	input  logic                   afi_phy_clk,
	input  logic                   arst_n,
	// request FIFO heads
	input  ddr_mux_pkg::wr_req_t   wr_head [2],
	input  logic [1:0]             wr_not_empty,
	input  ddr_mux_pkg::addr_t     rd_head [2],
	input  logic [1:0]             rd_not_empty,
	output logic [3:0]             pop,
	// local bus
	input  logic                   local_ready,
	output ddr_mux_pkg::local_cmd_t cmd,
	// read tag to the router
	output logic                   tag_push,
	output ddr_mux_pkg::port_tag_t tag,
	input  logic                   tag_full
);

	localparam int PORTS = `DDR_MUX_PORTS;

	ddr_mux_pkg::local_cmd_t next_cmd;
	ddr_mux_pkg::port_tag_t  cur_port;
	ddr_mux_pkg::port_tag_t  grant_port;
	logic                    served;
	logic                    grant_vld;
	logic                    can_issue;
	logic [PORTS-1:0]        req_vec;
	logic [PORTS-1:0]        last_mask;
	logic [PORTS-1:0]        cand;

	// a new command may be taken when the bus is idle or is being accepted now
	assign can_issue = !(cmd.write_req || cmd.read_req) || local_ready;

	// port order 0 wr, 1 rd, 2 wr, 3 rd
	// reads wait while the tag FIFO has no room
	assign req_vec = {rd_not_empty[1] & ~tag_full, wr_not_empty[1],
		rd_not_empty[0] & ~tag_full, wr_not_empty[0]};

	assign last_mask = served ? (PORTS'(1) << cur_port) : '0;

	//////////////////////////////////////////////////////////////////////
	// masked fixed priority, lowest index wins
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		cand       = ((req_vec & ~last_mask) != '0) ? (req_vec & ~last_mask) : req_vec;
		grant_vld  = 1'b0;
		grant_port = '0;
		for (int i = PORTS - 1; i >= 0; i--)
		begin
			if (cand[i])
			begin
				grant_vld  = 1'b1;
				grant_port = ddr_mux_pkg::port_tag_t'(i);
			end
		end
	end

	// odd ports read, upper bit picks the FIFO pair
	always_comb
	begin
		next_cmd           = '0;
		next_cmd.write_req = grant_vld & ~grant_port[0];
		next_cmd.read_req  = grant_vld & grant_port[0];
		if (grant_port[0])
			next_cmd.address = rd_head[grant_port[1]];
		else
		begin
			next_cmd.address = wr_head[grant_port[1]].addr;
			next_cmd.wdata   = wr_head[grant_port[1]].data;
		end
	end

	// entry leaves its FIFO at the edge where the command is registered
	assign pop = (can_issue && grant_vld) ? (PORTS'(1) << grant_port) : '0;

	assign tag_push = cmd.read_req & local_ready;
	assign tag      = cur_port;

	//////////////////////////////////////////////////////////////////////
	// command register, held while local_ready is low
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge afi_phy_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cmd      <= '0;
			cur_port <= '0;
			served   <= 1'b0;
		end
		else if (can_issue)
		begin
			cmd <= next_cmd;
			if (grant_vld)
			begin
				cur_port <= grant_port;
				served   <= 1'b1;
			end
		end
	end

endmodule

// ==== src/rdata_router.sv ====
// rdata_router: read tag FIFO and steering of returned data to the read ports
`timescale 1ns/10ps
`include "ddr_mux_defs.svh"

module rdata_router (
	input  logic                   afi_phy_clk,
	input  logic                   arst_n,
	input  logic                   tag_push,
	input  ddr_mux_pkg::port_tag_t tag,
	output logic                   tag_full,
	input  ddr_mux_pkg::data_t     local_rdata,
	input  logic                   local_rdata_valid,
	output ddr_mux_pkg::data_t     rd_data [2],
	output logic [1:0]             rd_data_valid
);

	localparam int DEPTH = `DDR_MUX_TAG_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	ddr_mux_pkg::port_tag_t tag_mem [DEPTH];
	ddr_mux_pkg::port_tag_t head_tag;
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [CNT_W-1:0]       count;

	// one slot stays free for a read still waiting on the bus
	assign tag_full = (count >= CNT_W'(DEPTH - 1));
	assign head_tag = tag_mem[rd_ptr];

	always_ff @(posedge afi_phy_clk)
	begin
		if (tag_push)
			tag_mem[wr_ptr] <= tag;
		// read tags are odd, bit 1 selects the port
		if (local_rdata_valid)
			rd_data[head_tag[1]] <= local_rdata;
	end

	always_ff @(posedge afi_phy_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			rd_data_valid <= '0;
		end
		else
		begin
			if (tag_push)
				wr_ptr <= wr_ptr + PTR_W'(1);
			if (local_rdata_valid)
				rd_ptr <= rd_ptr + PTR_W'(1);
			count <= count + CNT_W'(tag_push) - CNT_W'(local_rdata_valid);
			// single-cycle strobe on the owning port
			rd_data_valid <= local_rdata_valid ? (2'b01 << head_tag[1]) : 2'b00;
		end
	end

endmodule

// ==== src/mux_ddr_access.sv ====
// mux_ddr_access: top level with port FIFOs, command arbiter and read data router
`timescale 1ns/10ps

module mux_ddr_access (
	input  logic                afi_phy_clk,
	input  logic                arst_n,
	// port 0 write
	input  logic                wport_req_0,
	input  ddr_mux_pkg::addr_t  wport_addr_0,
	input  ddr_mux_pkg::data_t  wport_data_0,
	output logic                wport_ready_0,
	// port 1 read
	input  logic                rport_req_1,
	input  ddr_mux_pkg::addr_t  rport_addr_1,
	output logic                rport_ready_1,
	output ddr_mux_pkg::data_t  rport_data_1,
	output logic                rport_data_valid_1,
	// port 2 write
	input  logic                wport_req_2,
	input  ddr_mux_pkg::addr_t  wport_addr_2,
	input  ddr_mux_pkg::data_t  wport_data_2,
	output logic                wport_ready_2,
	// port 3 read
	input  logic                rport_req_3,
	input  ddr_mux_pkg::addr_t  rport_addr_3,
	output logic                rport_ready_3,
	output ddr_mux_pkg::data_t  rport_data_3,
	output logic                rport_data_valid_3,
	// DDR local interface
	output ddr_mux_pkg::addr_t  local_address,
	output ddr_mux_pkg::data_t  local_wdata,
	output logic                local_write_req,
	output logic                local_read_req,
	input  logic                local_ready,
	input  ddr_mux_pkg::data_t  local_rdata,
	input  logic                local_rdata_valid
);

	ddr_mux_pkg::wr_req_t    wr_in [2];
	ddr_mux_pkg::wr_req_t    wr_head [2];
	ddr_mux_pkg::addr_t      rd_head [2];
	ddr_mux_pkg::data_t      rd_data [2];
	ddr_mux_pkg::local_cmd_t cmd;
	ddr_mux_pkg::port_tag_t  tag;
	logic [1:0]              wr_not_empty;
	logic [1:0]              rd_not_empty;
	logic [1:0]              rd_data_valid;
	logic [3:0]              pop;
	logic                    tag_push;
	logic                    tag_full;

	assign wr_in[0] = '{addr: wport_addr_0, data: wport_data_0};
	assign wr_in[1] = '{addr: wport_addr_2, data: wport_data_2};

	//////////////////////////////////////////////////////////////////////
	// request queues
	//////////////////////////////////////////////////////////////////////

	port_req_fifo #(.payload_t(ddr_mux_pkg::wr_req_t)) u_wfifo_0 (
		.afi_phy_clk(afi_phy_clk), .arst_n(arst_n),
		.req(wport_req_0), .req_payload(wr_in[0]), .ready(wport_ready_0),
		.pop(pop[0]), .head(wr_head[0]), .not_empty(wr_not_empty[0]));

	port_req_fifo #(.payload_t(ddr_mux_pkg::addr_t)) u_rfifo_1 (
		.afi_phy_clk(afi_phy_clk), .arst_n(arst_n),
		.req(rport_req_1), .req_payload(rport_addr_1), .ready(rport_ready_1),
		.pop(pop[1]), .head(rd_head[0]), .not_empty(rd_not_empty[0]));

	port_req_fifo #(.payload_t(ddr_mux_pkg::wr_req_t)) u_wfifo_2 (
		.afi_phy_clk(afi_phy_clk), .arst_n(arst_n),
		.req(wport_req_2), .req_payload(wr_in[1]), .ready(wport_ready_2),
		.pop(pop[2]), .head(wr_head[1]), .not_empty(wr_not_empty[1]));

	port_req_fifo #(.payload_t(ddr_mux_pkg::addr_t)) u_rfifo_3 (
		.afi_phy_clk(afi_phy_clk), .arst_n(arst_n),
		.req(rport_req_3), .req_payload(rport_addr_3), .ready(rport_ready_3),
		.pop(pop[3]), .head(rd_head[1]), .not_empty(rd_not_empty[1]));

	//////////////////////////////////////////////////////////////////////
	// command issue and read return
	//////////////////////////////////////////////////////////////////////

	ddr_cmd_arbiter u_arbiter (
		.afi_phy_clk(afi_phy_clk), .arst_n(arst_n),
		.wr_head(wr_head), .wr_not_empty(wr_not_empty),
		.rd_head(rd_head), .rd_not_empty(rd_not_empty), .pop(pop),
		.local_ready(local_ready), .cmd(cmd),
		.tag_push(tag_push), .tag(tag), .tag_full(tag_full));

	rdata_router u_router (
		.afi_phy_clk(afi_phy_clk), .arst_n(arst_n),
		.tag_push(tag_push), .tag(tag), .tag_full(tag_full),
		.local_rdata(local_rdata), .local_rdata_valid(local_rdata_valid),
		.rd_data(rd_data), .rd_data_valid(rd_data_valid));

	assign local_address   = cmd.address;
	assign local_wdata     = cmd.wdata;
	assign local_write_req = cmd.write_req;
	assign local_read_req  = cmd.read_req;

	assign rport_data_1       = rd_data[0];
	assign rport_data_valid_1 = rd_data_valid[0];
	assign rport_data_3       = rd_data[1];
	assign rport_data_valid_3 = rd_data_valid[1];

endmodule

// ==== verification/mux_ddr_access_assert.sv ====
// concurrent assertions on the local bus and the read data strobes
`timescale 1ns/10ps

module mux_ddr_access_assert (
	input logic               afi_phy_clk,
	input logic               arst_n,
	input ddr_mux_pkg::addr_t local_address,
	input ddr_mux_pkg::data_t local_wdata,
	input logic               local_write_req,
	input logic               local_read_req,
	input logic               local_ready,
	input logic               rport_data_valid_1,
	input logic               rport_data_valid_3
);

	// one command type at a time
	no_dual_cmd: assert property (@(posedge afi_phy_clk) disable iff (!arst_n)
		!(local_write_req && local_read_req))
	else $error("write and read request high together");

	// stalled command holds until local_ready
	cmd_hold: assert property (@(posedge afi_phy_clk) disable iff (!arst_n)
		((local_write_req || local_read_req) && !local_ready) |=>
		$stable({local_address, local_wdata, local_write_req, local_read_req}))
	else $error("local command changed while not accepted");

	one_rd_valid: assert property (@(posedge afi_phy_clk) disable iff (!arst_n)
		!(rport_data_valid_1 && rport_data_valid_3))
	else $error("read data valid on both read ports");

endmodule

bind mux_ddr_access mux_ddr_access_assert u_assert (
	.afi_phy_clk(afi_phy_clk), .arst_n(arst_n),
	.local_address(local_address), .local_wdata(local_wdata),
	.local_write_req(local_write_req), .local_read_req(local_read_req),
	.local_ready(local_ready),
	.rport_data_valid_1(rport_data_valid_1), .rport_data_valid_3(rport_data_valid_3));

// ==== verification/mux_ddr_access_tb.sv ====
// testbench with clock, reset, DDR memory model, stimulus table and checks
`timescale 1ns/10ps
`include "ddr_mux_defs.svh"

module mux_ddr_access_tb;

	localparam int DEPTH   = `DDR_MUX_REQ_DEPTH;
	localparam int TIMEOUT = 2000;

	typedef struct packed {
		logic [1:0]         port;
		ddr_mux_pkg::addr_t addr;
		ddr_mux_pkg::data_t data;
		ddr_mux_pkg::data_t rdata;
	} row_t;

	// even ports write data, odd ports read and expect rdata
	localparam row_t ROWS [14] = '{
		'{2'd0, 32'h0000_0100, 32'hcafe_0001, 32'h0},
		'{2'd1, 32'h0000_0100, 32'h0, 32'hcafe_0001},
		'{2'd2, 32'h0000_0204, 32'h5eed_0002, 32'h0},
		'{2'd3, 32'h0000_0204, 32'h0, 32'h5eed_0002},
		'{2'd0, 32'h0000_0308, 32'h1234_5678, 32'h0},
		'{2'd2, 32'h0000_040c, 32'h9abc_def0, 32'h0},
		'{2'd1, 32'h0000_040c, 32'h0, 32'h9abc_def0},
		'{2'd3, 32'h0000_0308, 32'h0, 32'h1234_5678},
		'{2'd1, 32'h0000_0204, 32'h0, 32'h5eed_0002},
		'{2'd3, 32'h0000_0100, 32'h0, 32'hcafe_0001},
		'{2'd1, 32'h0000_0308, 32'h0, 32'h1234_5678},
		'{2'd3, 32'h0000_040c, 32'h0, 32'h9abc_def0},
		'{2'd0, 32'h0000_0100, 32'h0bad_f00d, 32'h0},
		'{2'd3, 32'h0000_0100, 32'h0, 32'h0bad_f00d}
	};

	logic                    afi_phy_clk = 1'b0;
	logic                    arst_n;
	logic [3:0]              req;
	logic [3:0]              ready;
	ddr_mux_pkg::addr_t      addr [4];
	ddr_mux_pkg::data_t      data [4];
	ddr_mux_pkg::addr_t      local_address;
	ddr_mux_pkg::data_t      local_wdata;
	logic                    local_write_req;
	logic                    local_read_req;
	logic                    local_ready;
	ddr_mux_pkg::data_t      local_rdata;
	logic                    local_rdata_valid;
	ddr_mux_pkg::data_t      rport_data_1;
	ddr_mux_pkg::data_t      rport_data_3;
	logic                    rport_data_valid_1;
	logic                    rport_data_valid_3;

	// DDR model state
	ddr_mux_pkg::data_t      mem [ddr_mux_pkg::addr_t];
	ddr_mux_pkg::local_cmd_t cmd_log [$];
	ddr_mux_pkg::data_t      exp_q1 [$];
	ddr_mux_pkg::data_t      exp_q3 [$];
	logic [31:0]             lfsr = 32'h41f0_d65a;
	logic [1:0]              pipe_v = 2'b00;
	ddr_mux_pkg::data_t      pipe_d [2];
	logic                    stall = 1'b0;
	logic                    b0;
	logic                    b1;
	logic                    rd_acc;
	int                      issued = 0;
	int                      accepted = 0;
	int                      load_cnt [4];

	mux_ddr_access u_mux_ddr_access (
		.afi_phy_clk(afi_phy_clk), .arst_n(arst_n),
		.wport_req_0(req[0]), .wport_addr_0(addr[0]), .wport_data_0(data[0]),
		.wport_ready_0(ready[0]),
		.rport_req_1(req[1]), .rport_addr_1(addr[1]), .rport_ready_1(ready[1]),
		.rport_data_1(rport_data_1), .rport_data_valid_1(rport_data_valid_1),
		.wport_req_2(req[2]), .wport_addr_2(addr[2]), .wport_data_2(data[2]),
		.wport_ready_2(ready[2]),
		.rport_req_3(req[3]), .rport_addr_3(addr[3]), .rport_ready_3(ready[3]),
		.rport_data_3(rport_data_3), .rport_data_valid_3(rport_data_valid_3),
		.local_address(local_address), .local_wdata(local_wdata),
		.local_write_req(local_write_req), .local_read_req(local_read_req),
		.local_ready(local_ready), .local_rdata(local_rdata),
		.local_rdata_valid(local_rdata_valid));

	always #10 afi_phy_clk = ~afi_phy_clk;

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// unwritten words follow a pattern of the whole address
	function automatic ddr_mux_pkg::data_t model_word(input ddr_mux_pkg::addr_t a);
		if (mem.exists(a))
			return mem[a];
		return {a[15:0], a[31:16]} ^ 32'h6d3a_c5e1;
	endfunction

	function automatic ddr_mux_pkg::addr_t load_addr(input int p, input int k);
		return 32'h0000_1000 | ddr_mux_pkg::addr_t'(p << 8) | ddr_mux_pkg::addr_t'(k);
	endfunction

	// lowest non-empty port, the last served one only if nothing else waits
	function automatic int next_port(input int last, input int cnt [4]);
		for (int p = 0; p < 4; p++)
		begin
			if (cnt[p] != 0 && p != last)
				return p;
		end
		return last;
	endfunction

	task automatic end_with_failure();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	task automatic report_mismatch(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		end_with_failure();
	endtask

	task automatic complain(input string msg);
		$display("timed out waiting for %s", msg);
		end_with_failure();
	endtask

	task automatic drive_port(input int p, input logic r, input ddr_mux_pkg::addr_t a,
		input ddr_mux_pkg::data_t d);
		req[p]  <= r;
		addr[p] <= a;
		data[p] <= d;
	endtask

	task automatic push_expected(input int p, input ddr_mux_pkg::data_t d);
		if (p == 1)
			exp_q1.push_back(d);
		else
			exp_q3.push_back(d);
	endtask

	// one request through a port, held until the port takes it
	task automatic send_req(input row_t row);
		int n;
		n = 0;
		@(posedge afi_phy_clk);
		drive_port(row.port, 1'b1, row.addr, row.data);
		do
		begin
			@(posedge afi_phy_clk);
			n++;
			if (n > TIMEOUT)
				complain("a port to accept a table request");
		end
		while (!ready[row.port]);
		req[row.port] <= 1'b0;
		issued++;
		if (row.port[0])
			push_expected(row.port, row.rdata);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (accepted != issued || exp_q1.size() != 0 || exp_q3.size() != 0)
		begin
			@(posedge afi_phy_clk);
			n++;
			if (n > TIMEOUT)
				complain("all commands and read data to drain");
		end
	endtask

	// all four ports push every cycle until each one reports full
	task automatic load_all_ports();
		logic [3:0] busy;
		int         n;
		busy = 4'hf;
		n    = 0;
		load_cnt = '{default: 0};
		@(posedge afi_phy_clk);
		for (int p = 0; p < 4; p++)
			drive_port(p, 1'b1, load_addr(p, 0), ~load_addr(p, 0));
		while (busy != 4'h0)
		begin
			@(posedge afi_phy_clk);
			n++;
			if (n > TIMEOUT)
				complain("port ready to drop while the local bus is stalled");
			for (int p = 0; p < 4; p++)
			begin
				if (busy[p] && ready[p])
				begin
					if (p % 2 == 1)
						push_expected(p, model_word(load_addr(p, load_cnt[p])));
					load_cnt[p]++;
					issued++;
					drive_port(p, 1'b1, load_addr(p, load_cnt[p]), ~load_addr(p, load_cnt[p]));
				end
				else if (busy[p])
				begin
					busy[p] = 1'b0;
					req[p] <= 1'b0;
				end
			end
		end
	endtask

	task automatic check_read(input int p, input ddr_mux_pkg::data_t got);
		ddr_mux_pkg::data_t exp;
		assert ((p == 1) ? (exp_q1.size() != 0) : (exp_q3.size() != 0))
		else report_mismatch($sformatf("read data on port %0d with no read pending", p));
		if (p == 1)
			exp = exp_q1.pop_front();
		else
			exp = exp_q3.pop_front();
		assert (got == exp)
		else report_mismatch($sformatf("port %0d read %h, expected %h", p, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// DDR model and read monitors
	//////////////////////////////////////////////////////////////////////

	// ready is high three cycles in four, reads return after 3 cycles
	always @(posedge afi_phy_clk)
	begin
		lfsr = lfsr_next(lfsr);
		b0   = lfsr[0];
		lfsr = lfsr_next(lfsr);
		b1   = lfsr[0];
		rd_acc = 1'b0;
		if (arst_n && local_ready && (local_write_req || local_read_req))
		begin
			cmd_log.push_back('{address: local_address, wdata: local_wdata,
				write_req: local_write_req, read_req: local_read_req});
			accepted++;
			if (local_write_req)
				mem[local_address] = local_wdata;
			rd_acc = local_read_req;
		end
		local_ready       <= !stall && (b0 || b1);
		pipe_v            <= {pipe_v[0], rd_acc};
		pipe_d[0]         <= model_word(local_address);
		pipe_d[1]         <= pipe_d[0];
		local_rdata_valid <= pipe_v[1];
		local_rdata       <= pipe_d[1];
	end

	always @(posedge afi_phy_clk)
	begin
		if (arst_n && rport_data_valid_1)
			check_read(1, rport_data_1);
		if (arst_n && rport_data_valid_3)
			check_read(3, rport_data_3);
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int   n;
		int   p;
		int   last;
		int   left [4];
		int   k [4];
		logic is_rd;
		arst_n            = 1'b0;
		req               = 4'h0;
		addr              = '{default: '0};
		data              = '{default: '0};
		local_ready       = 1'b0;
		local_rdata       = '0;
		local_rdata_valid = 1'b0;
		repeat (8) @(posedge afi_phy_clk);
		arst_n <= 1'b1;
		@(negedge afi_phy_clk);
		assert (!local_write_req && !local_read_req && !rport_data_valid_1 && !rport_data_valid_3)
		else report_mismatch("local request or read valid high after reset");
		assert (ready == 4'hf)
		else report_mismatch($sformatf("port ready %b after reset", ready));

		// writes wait on the bus so later reads see them
		for (int i = 0; i < $size(ROWS); i++)
		begin
			if (!ROWS[i].port[0])
				wait_drain();
			send_req(ROWS[i]);
			if (!ROWS[i].port[0])
				wait_drain();
		end
		wait_drain();

		// port 2 becomes the last served port
		send_req('{port: 2'd2, addr: 32'h0000_0f00, data: 32'h0f0f_0f0f, rdata: '0});
		wait_drain();

		stall <= 1'b1;
		n = 0;
		do
		begin
			@(posedge afi_phy_clk);
			n++;
			if (n > TIMEOUT)
				complain("local_ready to go low for the stall phase");
		end
		while (local_ready);
		cmd_log.delete();
		load_all_ports();

		// the first grant sits on the bus, so its port took one more request
		p = next_port(2, '{1, 1, 1, 1});
		for (int i = 0; i < 4; i++)
		begin
			assert (load_cnt[i] == DEPTH + ((i == p) ? 1 : 0))
			else report_mismatch($sformatf("port %0d accepted %0d requests", i, load_cnt[i]));
		end

		stall <= 1'b0;
		n = 0;
		while (cmd_log.size() < 4 * DEPTH + 1)
		begin
			@(posedge afi_phy_clk);
			n++;
			if (n > TIMEOUT)
				complain("queued requests to reach the local bus");
		end

		// replay the masked priority over the known queue contents
		left = load_cnt;
		k    = '{default: 0};
		last = 2;
		for (int i = 0; i < 4 * DEPTH + 1; i++)
		begin
			p     = next_port(last, left);
			is_rd = (p % 2) == 1;
			assert (cmd_log[i].address == load_addr(p, k[p]) &&
				cmd_log[i].write_req == !is_rd && cmd_log[i].read_req == is_rd)
			else report_mismatch($sformatf("command %0d address %h, expected port %0d address %h",
				i, cmd_log[i].address, p, load_addr(p, k[p])));
			assert (is_rd || cmd_log[i].wdata == ~load_addr(p, k[p]))
			else report_mismatch($sformatf("command %0d write data %h", i, cmd_log[i].wdata));
			left[p]--;
			k[p]++;
			last = p;
		end

		wait_drain();
		@(negedge afi_phy_clk);
		assert (ready == 4'hf)
		else report_mismatch($sformatf("port ready %b after the queues drained", ready));
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== mux_ddr_access.f ====
+incdir+include
src/ddr_mux_pkg.sv
src/port_req_fifo.sv
src/ddr_cmd_arbiter.sv
src/rdata_router.sv
src/mux_ddr_access.sv
verification/mux_ddr_access_assert.sv
verification/mux_ddr_access_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f mux_ddr_access.f \
	--top-module mux_ddr_access_tb -o mux_ddr_access_sim &&
./obj_dir/mux_ddr_access_sim ||
{ echo "simulation build or run failed"; exit 1; }
